// ==== wb_pkg.sv ====
package wb_pkg;

    // line address width
    localparam int ADDR_WIDTH = 32;

    // log2 of words per line
    localparam int OFFSET_WIDTH = 2;

    // words per line, one beat each
    localparam int BEATS = 1 << OFFSET_WIDTH;

    localparam int WORD_WIDTH = 32;
    localparam int LINE_WIDTH = BEATS * WORD_WIDTH;

    // number of buffer entries
    localparam int WB_DEPTH = 5;

    // must hold values 0..WB_DEPTH
    localparam int COUNT_WIDTH = 3;

    // line writer burst phases
    typedef enum logic [1:0] {
        BURST_IDLE = 2'd0,
        BURST_ADDR = 2'd1,
        BURST_DATA = 2'd2,
        BURST_RESP = 2'd3
    } burst_state_e;

    // insert side handshake
    typedef enum logic {
        INS_IDLE = 1'b0,
        INS_ACK  = 1'b1
    } insert_state_e;

endpackage

// ==== wb_store.sv ====
`timescale 1ns/1ps

module wb_store
    import wb_pkg::*;
(
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           in_valid,
    input  logic [ADDR_WIDTH-1:0]          in_addr,
    input  logic [LINE_WIDTH-1:0]          in_data,
    output logic                           in_ready,
    input  logic                           line_done,
    output logic [COUNT_WIDTH-1:0]         count,
    output logic [WB_DEPTH*ADDR_WIDTH-1:0] entry_addr,
    output logic [WB_DEPTH*LINE_WIDTH-1:0] entry_data,
    output logic [ADDR_WIDTH-1:0]          head_addr,
    output logic [LINE_WIDTH-1:0]          head_data,
    output logic                           head_valid
);

    insert_state_e ins_state;
    insert_state_e ins_next;

    logic [ADDR_WIDTH-1:0]  addr_q [WB_DEPTH];
    logic [LINE_WIDTH-1:0]  data_q [WB_DEPTH];
    logic                   insert_fire;
    logic [COUNT_WIDTH-1:0] head_idx;

    // accept only when idle and not full
    assign insert_fire = (ins_state == INS_IDLE) && in_valid &&
                         (count < COUNT_WIDTH'(WB_DEPTH));

    always_comb begin
        ins_next = ins_state;
        case (ins_state)
            INS_IDLE: begin
                if (insert_fire) begin
                    ins_next = INS_ACK;
                end
            end
            INS_ACK: ins_next = INS_IDLE;
            default: ins_next = INS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ins_state <= INS_IDLE;
        end else begin
            ins_state <= ins_next;
        end
    end

    // one-cycle ack after the line is captured
    assign in_ready = (ins_state == INS_ACK);

    // newest line lands in slot 0, everything else ages by one
    always_ff @(posedge clk) begin
        if (insert_fire) begin
            addr_q[0] <= in_addr;
            data_q[0] <= in_data;
            for (int i = 1; i < WB_DEPTH; i++) begin
                addr_q[i] <= addr_q[i-1];
                data_q[i] <= data_q[i-1];
            end
        end
    end

    // simultaneous insert and free cancel out
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else begin
            case ({insert_fire, line_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < WB_DEPTH; i++) begin
            entry_addr[i*ADDR_WIDTH +: ADDR_WIDTH] = addr_q[i];
            entry_data[i*LINE_WIDTH +: LINE_WIDTH] = data_q[i];
        end
    end

    // oldest valid entry sits at count-1
    assign head_idx   = (count == '0) ? '0 : count - 1'b1;
    assign head_valid = (count != '0);
    assign head_addr  = addr_q[head_idx];
    assign head_data  = data_q[head_idx];

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rstn)
        count <= COUNT_WIDTH'(WB_DEPTH)
    );

    // a response must always belong to a buffered line
    a_free_nonempty: assert property (
        @(posedge clk) disable iff (!rstn)
        line_done |-> (count != '0)
    );

endmodule

// ==== wb_lookup.sv ====
`timescale 1ns/1ps

module wb_lookup
    import wb_pkg::*;
(
    input  logic [COUNT_WIDTH-1:0]         count,
    input  logic [WB_DEPTH*ADDR_WIDTH-1:0] entry_addr,
    input  logic [WB_DEPTH*LINE_WIDTH-1:0] entry_data,
    input  logic [ADDR_WIDTH-1:0]          query_addr,
    output logic                           query_hit,
    output logic [LINE_WIDTH-1:0]          query_data
);

    logic [WB_DEPTH-1:0] match;

    // slots at or beyond count are stale
    always_comb begin
        for (int i = 0; i < WB_DEPTH; i++) begin
            match[i] = (COUNT_WIDTH'(i) < count) &&
                       (entry_addr[i*ADDR_WIDTH +: ADDR_WIDTH] == query_addr);
        end
    end

    // walk oldest to youngest so the lowest index wins
    always_comb begin
        query_hit  = 1'b0;
        query_data = '0;
        for (int i = WB_DEPTH - 1; i >= 0; i--) begin
            if (match[i]) begin
                query_hit  = 1'b1;
                query_data = entry_data[i*LINE_WIDTH +: LINE_WIDTH];
            end
        end
    end

endmodule

// ==== axi_line_writer.sv ====
`timescale 1ns/1ps

module axi_line_writer
    import wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  head_valid,
    input  logic [ADDR_WIDTH-1:0] head_addr,
    input  logic [LINE_WIDTH-1:0] head_data,
    output logic                  line_done,
    output logic [ADDR_WIDTH-1:0] awaddr,
    output logic                  awvalid,
    input  logic                  awready,
    output logic [WORD_WIDTH-1:0] wdata,
    output logic                  wvalid,
    output logic                  wlast,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready
);

    burst_state_e state;
    burst_state_e state_next;

    logic [OFFSET_WIDTH-1:0] beat;
    logic [ADDR_WIDTH-1:0]   addr_q;
    logic [LINE_WIDTH-1:0]   line_q;
    logic                    last_beat;

    assign last_beat = (beat == OFFSET_WIDTH'(BEATS - 1));

    always_comb begin
        state_next = state;
        case (state)
            BURST_IDLE: begin
                if (head_valid) begin
                    state_next = BURST_ADDR;
                end
            end
            BURST_ADDR: begin
                if (awready) begin
                    state_next = BURST_DATA;
                end
            end
            BURST_DATA: begin
                if (wready && last_beat) begin
                    state_next = BURST_RESP;
                end
            end
            BURST_RESP: begin
                if (bvalid) begin
                    state_next = BURST_IDLE;
                end
            end
            default: state_next = BURST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= BURST_IDLE;
            beat  <= '0;
        end else begin
            state <= state_next;
            if (state == BURST_ADDR) begin
                beat <= '0;
            end else if (state == BURST_DATA && wready) begin
                beat <= beat + 1'b1;
            end
        end
    end

    // snapshot of the head line, taken as the burst starts
    always_ff @(posedge clk) begin
        if (state == BURST_IDLE && head_valid) begin
            addr_q <= head_addr;
            line_q <= head_data;
        end
    end

    assign awvalid = (state == BURST_ADDR);
    assign awaddr  = addr_q;

    // low word first
    assign wvalid = (state == BURST_DATA);
    assign wdata  = line_q[WORD_WIDTH*beat +: WORD_WIDTH];
    assign wlast  = (state == BURST_DATA) && last_beat;

    assign bready    = (state == BURST_RESP);
    assign line_done = (state == BURST_RESP) && bvalid;

    // last beat carries the top word of the line still at the head
    a_wlast_in_beat: assert property (
        @(posedge clk) disable iff (!rstn)
        wlast |-> (wvalid && wdata == head_data[LINE_WIDTH-WORD_WIDTH +: WORD_WIDTH])
    );

    // the head must not move while the address waits
    a_aw_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        (awvalid && !awready) |=> (awvalid && awaddr == head_addr)
    );

endmodule

// ==== write_buffer_top.sv ====
`timescale 1ns/1ps

module write_buffer_top
    import wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  in_valid,
    input  logic [ADDR_WIDTH-1:0] in_addr,
    input  logic [LINE_WIDTH-1:0] in_data,
    output logic                  in_ready,
    input  logic [ADDR_WIDTH-1:0] query_addr,
    output logic                  query_hit,
    output logic [LINE_WIDTH-1:0] query_data,
    output logic [ADDR_WIDTH-1:0] awaddr,
    output logic                  awvalid,
    input  logic                  awready,
    output logic [WORD_WIDTH-1:0] wdata,
    output logic                  wvalid,
    output logic                  wlast,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready
);

    logic [COUNT_WIDTH-1:0]         count;
    logic [WB_DEPTH*ADDR_WIDTH-1:0] entry_addr;
    logic [WB_DEPTH*LINE_WIDTH-1:0] entry_data;
    logic [ADDR_WIDTH-1:0]          head_addr;
    logic [LINE_WIDTH-1:0]          head_data;
    logic                           head_valid;
    logic                           line_done;

    wb_store wb_store_inst (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_addr    (in_addr),
        .in_data    (in_data),
        .in_ready   (in_ready),
        .line_done  (line_done),
        .count      (count),
        .entry_addr (entry_addr),
        .entry_data (entry_data),
        .head_addr  (head_addr),
        .head_data  (head_data),
        .head_valid (head_valid)
    );

    wb_lookup wb_lookup_inst (
        .count      (count),
        .entry_addr (entry_addr),
        .entry_data (entry_data),
        .query_addr (query_addr),
        .query_hit  (query_hit),
        .query_data (query_data)
    );

    axi_line_writer axi_line_writer_inst (
        .clk        (clk),
        .rstn       (rstn),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .head_data  (head_data),
        .line_done  (line_done),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wlast      (wlast),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready)
    );

endmodule

// ==== tb_mem_slave.sv ====
`timescale 1ns/1ps

module tb_mem_slave
    import wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  stall_en,
    input  logic                  hold_aw,
    input  logic                  hold_b,
    input  logic [ADDR_WIDTH-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [WORD_WIDTH-1:0] wdata,
    input  logic                  wvalid,
    input  logic                  wlast,
    output logic                  wready,
    output logic                  bvalid,
    input  logic                  bready,
    output logic                  rec_valid,
    output logic [ADDR_WIDTH-1:0] rec_addr,
    output logic [LINE_WIDTH-1:0] rec_data,
    output logic                  beat_err
);

    integer                seed;
    int                    beat;
    logic                  b_fire;
    logic                  b_owed;
    logic [ADDR_WIDTH-1:0] cur_addr;
    logic [LINE_WIDTH-1:0] cur_line;

    initial begin
        seed      = 32'hcd20;
        beat      = 0;
        b_fire    = 1'b0;
        b_owed    = 1'b0;
        cur_addr  = '0;
        cur_line  = '0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        rec_valid = 1'b0;
        rec_addr  = '0;
        rec_data  = '0;
        beat_err  = 1'b0;
    end

    // handshakes sampled mid-cycle, they complete at the next rising edge
    always @(negedge clk) begin
        b_fire = rstn && bvalid && bready;
        if (!rstn || b_fire) begin
            b_owed = 1'b0;
        end
        if (awvalid && awready) begin
            cur_addr = awaddr;
            beat     = 0;
        end
        if (wvalid && wready) begin
            if (beat >= BEATS || wlast != (beat == BEATS - 1)) begin
                beat_err = 1'b1;
            end else begin
                cur_line[WORD_WIDTH*beat +: WORD_WIDTH] = wdata;
            end
            beat = beat + 1;
            if (beat == BEATS) begin
                b_owed = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        #1;
        rec_valid = 1'b0;
        if (!rstn) begin
            awready = 1'b0;
            wready  = 1'b0;
            bvalid  = 1'b0;
        end else begin
            if (b_fire) begin
                // line is complete once the response is taken
                bvalid    = 1'b0;
                rec_valid = 1'b1;
                rec_addr  = cur_addr;
                rec_data  = cur_line;
            end else if (b_owed && !bvalid && !hold_b &&
                         (!stall_en || ($random(seed) & 1) == 0)) begin
                bvalid = 1'b1;
            end
            if (stall_en) begin
                awready = !hold_aw && (($random(seed) & 3) != 0);
                wready  = (($random(seed) & 3) != 0);
            end else begin
                awready = !hold_aw;
                wready  = 1'b1;
            end
        end
    end

endmodule

// ==== tb_write_buffer.sv ====
`timescale 1ns/1ps

module tb_write_buffer
    import wb_pkg::*;
();

    // about 35 lines at roughly 60 stalled cycles each, plus reset and margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic                  clk;
    logic                  rstn;
    logic                  in_valid;
    logic [ADDR_WIDTH-1:0] in_addr;
    logic [LINE_WIDTH-1:0] in_data;
    logic                  in_ready;
    logic [ADDR_WIDTH-1:0] query_addr;
    logic                  query_hit;
    logic [LINE_WIDTH-1:0] query_data;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [WORD_WIDTH-1:0] wdata;
    logic                  wvalid;
    logic                  wlast;
    logic                  wready;
    logic                  bvalid;
    logic                  bready;
    logic                  stall_en;
    logic                  hold_aw;
    logic                  hold_b;
    logic                  rec_valid;
    logic [ADDR_WIDTH-1:0] rec_addr;
    logic [LINE_WIDTH-1:0] rec_data;
    logic                  beat_err;

    integer seed;
    int     issued;
    int     ack_count;
    int     lines_seen;
    int     cycles;
    string  test_name;

    // pending lines, oldest at the front
    logic [ADDR_WIDTH-1:0] ref_addr[$];
    logic [LINE_WIDTH-1:0] ref_data[$];

    write_buffer_top write_buffer_top_inst (
        .clk(clk), .rstn(rstn),
        .in_valid(in_valid), .in_addr(in_addr), .in_data(in_data), .in_ready(in_ready),
        .query_addr(query_addr), .query_hit(query_hit), .query_data(query_data),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wlast(wlast), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

    tb_mem_slave mem_slave_inst (
        .clk(clk), .rstn(rstn), .stall_en(stall_en), .hold_aw(hold_aw), .hold_b(hold_b),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wlast(wlast), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .rec_valid(rec_valid), .rec_addr(rec_addr), .rec_data(rec_data), .beat_err(beat_err)
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        abort_run();
    endtask

    task automatic check_line(input string name, input logic [LINE_WIDTH-1:0] exp,
                              input logic [LINE_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] exp,
                              input logic [ADDR_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_hit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAILED %s: expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // youngest matching pending line, or a zero miss
    function automatic logic [LINE_WIDTH:0] expected_query(input logic [ADDR_WIDTH-1:0] addr);
        logic [LINE_WIDTH:0] result;
        result = '0;
        for (int i = 0; i < ref_addr.size(); i++) begin
            if (ref_addr[i] == addr) begin
                result = {1'b1, ref_data[i]};
            end
        end
        return result;
    endfunction

    task automatic insert_line(input logic [ADDR_WIDTH-1:0] addr,
                               input logic [LINE_WIDTH-1:0] data);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_addr  = addr;
        in_data  = data;
        issued   = issued + 1;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // sampled after the mid-cycle model update
    task automatic query_check(input string name, input logic [ADDR_WIDTH-1:0] addr);
        logic [LINE_WIDTH:0] exp;
        @(posedge clk);
        #1;
        query_addr = addr;
        #2;
        exp = expected_query(addr);
        check_hit(name, exp[LINE_WIDTH], query_hit);
        check_line(name, exp[LINE_WIDTH-1:0], query_data);
    endtask

    task automatic set_mem_stalls(input logic stall, input logic aw, input logic b);
        @(posedge clk);
        #1;
        stall_en = stall;
        hold_aw  = aw;
        hold_b   = b;
    endtask

    task automatic wait_drained();
        @(posedge clk);
        while (ref_addr.size() != 0) @(posedge clk);
    endtask

    // reference model update and drain order compare
    always @(negedge clk) begin
        if (rstn) begin
            if (in_ready) begin
                ref_addr.push_back(in_addr);
                ref_data.push_back(in_data);
                ack_count = ack_count + 1;
            end
            if (rec_valid) begin
                if (ref_addr.size() == 0) begin
                    report_error("memory received a line that was never inserted");
                end else begin
                    check_addr({test_name, " drain addr"}, ref_addr[0], rec_addr);
                    check_line({test_name, " drain data"}, ref_data[0], rec_data);
                    void'(ref_addr.pop_front());
                    void'(ref_data.pop_front());
                    lines_seen = lines_seen + 1;
                end
            end
            if (beat_err) begin
                report_error("wlast was not seen on exactly the fourth beat of a burst");
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial begin
        logic [ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0] data;
        logic [LINE_WIDTH-1:0] older;
        integer                r;
        int                    base;
        clk        = 1'b0;
        rstn       = 1'b0;
        in_valid   = 1'b0;
        in_addr    = '0;
        in_data    = '0;
        query_addr = '0;
        stall_en   = 1'b0;
        hold_aw    = 1'b0;
        hold_b     = 1'b0;
        seed       = 32'hcd20;
        issued     = 0;
        ack_count  = 0;
        lines_seen = 0;
        cycles     = 0;
        test_name  = "reset";
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        query_check(test_name, 32'h0000_1000);

        // two copies of one address, newer data must win
        test_name = "same_addr";
        set_mem_stalls(1'b0, 1'b1, 1'b0);
        older = {$random(seed), $random(seed), $random(seed), $random(seed)};
        data  = {$random(seed), $random(seed), $random(seed), $random(seed)};
        insert_line(32'h0000_2000, older);
        insert_line(32'h0000_2000, data);
        query_check(test_name, 32'h0000_2000);
        check_hit(test_name, 1'b1, query_hit);
        check_line(test_name, data, query_data);
        query_check("never_inserted", 32'h0000_3000);
        check_hit("never_inserted", 1'b0, query_hit);
        set_mem_stalls(1'b0, 1'b0, 1'b0);
        wait_drained();
        query_check("completed_line", 32'h0000_2000);
        check_hit("completed_line", 1'b0, query_hit);
        check_line("completed_line", '0, query_data);

        test_name = "full_buffer";
        set_mem_stalls(1'b1, 1'b1, 1'b0);
        for (int n = 0; n < WB_DEPTH; n++) begin
            data = {$random(seed), $random(seed), $random(seed), $random(seed)};
            insert_line(32'h0000_4000 + (n << 4), data);
        end
        addr = 32'h0000_4100;
        data = {$random(seed), $random(seed), $random(seed), $random(seed)};
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_addr  = addr;
        in_data  = data;
        issued   = issued + 1;
        base     = lines_seen;
        repeat (12) begin
            @(negedge clk);
            if (in_ready) begin
                report_error("sixth insert was acknowledged while the buffer was full");
            end
        end
        set_mem_stalls(1'b0, 1'b0, 1'b0);
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        if (lines_seen == base) begin
            report_error("sixth insert was acknowledged before any write response");
        end
        wait_drained();
        query_check(test_name, addr);

        // response held off, the draining line must stay visible
        test_name = "stalled_resp";
        set_mem_stalls(1'b1, 1'b0, 1'b1);
        addr = 32'h0000_5000;
        data = {$random(seed), $random(seed), $random(seed), $random(seed)};
        insert_line(addr, data);
        @(negedge clk);
        while (!bready) @(negedge clk);
        repeat (10) begin
            query_check(test_name, addr);
            check_hit(test_name, 1'b1, query_hit);
            check_line(test_name, data, query_data);
        end
        base = lines_seen;
        set_mem_stalls(1'b1, 1'b0, 1'b0);
        while (lines_seen == base) query_check(test_name, addr);
        query_check(test_name, addr);
        check_hit(test_name, 1'b0, query_hit);

        // small address pool so duplicates show up
        test_name = "random_mix";
        set_mem_stalls(1'b1, 1'b0, 1'b0);
        for (int n = 0; n < 24; n++) begin
            r    = $random(seed);
            addr = 32'h0000_1000 | ((r & 7) << 4);
            data = {$random(seed), $random(seed), $random(seed), $random(seed)};
            insert_line(addr, data);
            r = $random(seed);
            query_check(test_name, 32'h0000_1000 | ((r & 7) << 4));
        end
        wait_drained();

        // every acknowledged line is recorded, so no further burst may start
        repeat (2) @(posedge clk);
        #1;
        if (awvalid || wvalid || bready) begin
            report_error("write channel still active after every line was recorded");
        end

        check_count("ack_count", issued, ack_count);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== compile.f ====
wb_pkg.sv
wb_store.sv
wb_lookup.sv
axi_line_writer.sv
write_buffer_top.sv
tb_mem_slave.sv
tb_write_buffer.sv

// ==== run.sh ====
#!/bin/sh
# build and run the write buffer testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_write_buffer \
    -f compile.f -o tb_write_buffer \
    && ./obj_dir/tb_write_buffer > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "Test completed successfully" sim.log && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }
